// ==== list.f ====
+incdir+.
simd_cpu_pkg.sv
simd_cpu_ifs.sv
fetch_decode.sv
reg_file.sv
simd_alu.sv
execute_stage.sv
writeback_stage.sv
simd_cpu_top.sv
tb_simd_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the simd cpu testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_simd_cpu \
	-Mdir obj_dir -o sim_tb -f list.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0

// ==== tb_simd_cpu.sv ====
`timescale 1ns/1ps
`include "simd_cpu_params.svh"

module tb_simd_cpu;

	localparam int PROG_SZ = 512;
	localparam int MEM_SZ  = 256;
	localparam int LIMIT   = 1000; // drain timeout in cycles

	logic                     CLK;
	logic                     RST;
	logic [`SIMD_INSTR_W-1:0] instruction = '0;
	logic [`SIMD_DATA_W-1:0]  data_in     = '0;
	logic [`SIMD_ADDR_W-1:0]  pc;
	logic [`SIMD_DATA_W-1:0]  data_out;
	logic [`SIMD_ADDR_W-1:0]  mem_addr;
	logic                     mem_en;
	logic                     mem_wr_en;

	// program and per-slot expectations for the execute stage
	logic [31:0] prog      [PROG_SZ];
	logic        slot_en   [PROG_SZ];
	logic        slot_wr   [PROG_SZ];
	logic [31:0] slot_addr [PROG_SZ];
	logic [63:0] slot_data [PROG_SZ];
	logic [63:0] dmem      [MEM_SZ];
	logic [63:0] mreg      [32]; // register file model

	int          n_slots;
	int          n_stores;
	int          stores_seen;
	int          cyc;
	int          seed;
	logic [15:0] st_ptr;
	int          err_pc;
	int          err_strobe;
	int          err_addr;
	int          err_store;
	int          err_count;
	logic        timed_out;
	logic        exp_en;
	logic        exp_wr;
	logic [31:0] exp_addr;
	logic [63:0] exp_data;

	simd_cpu_top simd_cpu_top_i (
		.CLK           (CLK),
		.RST           (RST),
		.i_instruction (instruction),
		.i_data_in     (data_in),
		.o_pc          (pc),
		.o_data_out    (data_out),
		.o_mem_addr    (mem_addr),
		.o_mem_en      (mem_en),
		.o_mem_wr_en   (mem_wr_en)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// cycles since reset release
	always_ff @(posedge CLK) begin
		if (RST) cyc <= 0;
		else     cyc <= cyc + 1;
	end

	// instruction sampled at cycle c sits in execute at cycle c+2
	always_comb begin
		exp_en   = 1'b0;
		exp_wr   = 1'b0;
		exp_addr = '0;
		exp_data = '0;
		if ((cyc >= 2) && (cyc - 2 < PROG_SZ)) begin
			exp_en   = slot_en[cyc - 2];
			exp_wr   = slot_wr[cyc - 2];
			exp_addr = slot_addr[cyc - 2];
			exp_data = slot_data[cyc - 2];
		end
	end

	// instruction and data memory models
	always @(negedge CLK) begin
		instruction = prog[pc[10:2]];
		data_in     = dmem[mem_addr[7:0]];
		if (mem_wr_en) stores_seen++;
	end

	// ------------------------------
	// checks
	// ------------------------------
	pc_step_chk: assert property (@(posedge CLK) disable iff (RST) pc == 32'(cyc * 4))
		else begin
			err_pc++;
			$display("[FAIL] %0t: pc %h, expected %h", $time, $sampled(pc),
				32'($sampled(cyc) * 4));
		end

	strobe_chk: assert property (@(posedge CLK) disable iff (RST)
		(mem_en == exp_en) && (mem_wr_en == exp_wr))
		else begin
			err_strobe++;
			$display("[FAIL] %0t: strobes en/wr %b%b, expected %b%b", $time,
				$sampled(mem_en), $sampled(mem_wr_en), $sampled(exp_en), $sampled(exp_wr));
		end

	addr_chk: assert property (@(posedge CLK) disable iff (RST) mem_en |-> mem_addr == exp_addr)
		else begin
			err_addr++;
			$display("[FAIL] %0t: mem addr %h, expected %h", $time,
				$sampled(mem_addr), $sampled(exp_addr));
		end

	store_data_chk: assert property (@(posedge CLK) disable iff (RST)
		mem_wr_en |-> data_out == exp_data)
		else begin
			err_store++;
			$display("[FAIL] %0t: store data %h, expected %h", $time,
				$sampled(data_out), $sampled(exp_data));
		end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic logic [63:0] lane_ones(input int w);
		lane_ones = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
	endfunction

	function automatic logic [63:0] model_alu(input logic [5:0] fn, input logic [1:0] ww,
		input logic [4:0] sh_f, input logic [63:0] a, input logic [63:0] b);
		int          w;
		int          s;
		int          l;
		logic [63:0] m;
		logic [63:0] x;
		logic [63:0] y;
		logic [63:0] r;
		logic [63:0] res;
		w = 8 << ww;
		m = lane_ones(w);
		if (ww == `SIMD_WW_B)      s = int'(sh_f[2:0]);
		else if (ww == `SIMD_WW_H) s = int'(sh_f[3:0]);
		else                       s = int'(sh_f);
		res = '0;
		for (l = 0; l < 64 / w; l++) begin
			x = (a >> (l * w)) & m;
			y = (b >> (l * w)) & m;
			case (fn)
				`SIMD_FN_ADD:  r = (x + y) & m;
				`SIMD_FN_SUB:  r = (x - y) & m;
				`SIMD_FN_SLLI: r = (x << s) & m;
				`SIMD_FN_SRLI: r = x >> s;
				`SIMD_FN_SRAI: begin
					r = x >> s;
					if (x[w-1]) r = r | (m & ~(m >> s)); // copy sign into vacated bits
				end
				default:       r = '0;
			endcase
			res = res | (r << (l * w));
		end
		case (fn)
			`SIMD_FN_AND: res = a & b;
			`SIMD_FN_OR:  res = a | b;
			`SIMD_FN_XOR: res = a ^ b;
			`SIMD_FN_NOT: res = ~a;
			`SIMD_FN_MOV: res = a;
			default: ;
		endcase
		model_alu = res;
	endfunction

	// lane i counted from the msb end
	function automatic logic [63:0] write_mask(input logic [2:0] ppp, input logic [1:0] ww);
		int          w;
		int          i;
		logic [63:0] m;
		w = 8 << ww;
		case (ppp)
			`SIMD_PPP_UPPER: m = {32'hffff_ffff, 32'h0};
			`SIMD_PPP_LOWER: m = {32'h0, 32'hffff_ffff};
			`SIMD_PPP_EVEN, `SIMD_PPP_ODD: begin
				m = '0;
				for (i = 0; i < 64 / w; i++) begin
					if (((i % 2) == 0) == (ppp == `SIMD_PPP_EVEN))
						m = m | (lane_ones(w) << (64 - (i + 1) * w));
				end
			end
			default:         m = '1;
		endcase
		write_mask = m;
	endfunction

	// ------------------------------
	// program builders
	// ------------------------------
	task automatic place_slot(input logic [31:0] word, input logic en, input logic wr,
		input logic [15:0] addr, input logic [63:0] data);
		prog[n_slots]      = word;
		slot_en[n_slots]   = en;
		slot_wr[n_slots]   = wr;
		slot_addr[n_slots] = {16'h0, addr};
		slot_data[n_slots] = data;
		n_slots += 3; // two nop slots follow
	endtask

	task automatic load_reg(input logic [4:0] rd, input logic [15:0] addr);
		place_slot({`SIMD_OP_LOAD, rd, 5'd0, addr}, 1'b1, 1'b0, addr, '0);
		if (rd != 5'd0) mreg[rd] = dmem[addr[7:0]];
	endtask

	task automatic store_reg(input logic [4:0] rs);
		place_slot({`SIMD_OP_STORE, rs, 5'd0, st_ptr}, 1'b1, 1'b1, st_ptr, mreg[rs]);
		st_ptr++;
		n_stores++;
	endtask

	task automatic issue_alu(input logic [5:0] fn, input logic [4:0] rd, input logic [4:0] ra,
		input logic [4:0] rb, input logic [1:0] ww, input logic [2:0] ppp);
		logic [63:0] res;
		logic [63:0] m;
		place_slot({`SIMD_OP_RTYPE, rd, ra, rb, ppp, ww, fn}, 1'b0, 1'b0, '0, '0);
		res = model_alu(fn, ww, rb, mreg[ra], mreg[rb]);
		m   = write_mask(ppp, ww);
		if (rd != 5'd0) mreg[rd] = (mreg[rd] & ~m) | (res & m);
	endtask

	task automatic build_program();
		int w;
		int p;
		load_reg(5'd1, 16'h10);
		load_reg(5'd2, 16'h11);
		load_reg(5'd3, 16'h20);
		load_reg(5'd4, 16'h8012); // address bit 15 set
		store_reg(5'd1); // plain round trip
		issue_alu(`SIMD_FN_AND, 5'd5, 5'd1, 5'd2, `SIMD_WW_D, `SIMD_PPP_ALL);
		store_reg(5'd5);
		issue_alu(`SIMD_FN_OR, 5'd5, 5'd1, 5'd2, `SIMD_WW_D, `SIMD_PPP_ALL);
		store_reg(5'd5);
		issue_alu(`SIMD_FN_XOR, 5'd5, 5'd1, 5'd2, `SIMD_WW_D, `SIMD_PPP_ALL);
		store_reg(5'd5);
		issue_alu(`SIMD_FN_NOT, 5'd5, 5'd1, 5'd0, `SIMD_WW_D, `SIMD_PPP_ALL);
		store_reg(5'd5);
		issue_alu(`SIMD_FN_MOV, 5'd5, 5'd2, 5'd0, `SIMD_WW_D, `SIMD_PPP_ALL);
		store_reg(5'd5);
		for (w = 0; w < 4; w++) begin
			issue_alu(`SIMD_FN_ADD, 5'd6, 5'd1, 5'd3, 2'(w), `SIMD_PPP_ALL);
			store_reg(5'd6);
			issue_alu(`SIMD_FN_ADD, 5'd6, 5'd3, 5'd3, 2'(w), `SIMD_PPP_ALL); // lane carry drop
			store_reg(5'd6);
			issue_alu(`SIMD_FN_SUB, 5'd6, 5'd2, 5'd3, 2'(w), `SIMD_PPP_ALL);
			store_reg(5'd6);
		end
		for (w = 0; w < 4; w++) begin
			issue_alu(`SIMD_FN_SLLI, 5'd7, 5'd3, 5'd29, 2'(w), `SIMD_PPP_ALL);
			store_reg(5'd7);
			issue_alu(`SIMD_FN_SRLI, 5'd7, 5'd3, 5'd29, 2'(w), `SIMD_PPP_ALL);
			store_reg(5'd7);
			issue_alu(`SIMD_FN_SRAI, 5'd7, 5'd3, 5'd29, 2'(w), `SIMD_PPP_ALL);
			store_reg(5'd7);
			issue_alu(`SIMD_FN_SRAI, 5'd7, 5'd3, 5'd3, 2'(w), `SIMD_PPP_ALL);
			store_reg(5'd7);
		end
		// masked writes over a known prior value
		for (p = 1; p <= 4; p++) begin
			for (w = 0; w < 4; w++) begin
				issue_alu(`SIMD_FN_MOV, 5'd8, 5'd4, 5'd0, `SIMD_WW_D, `SIMD_PPP_ALL);
				issue_alu(`SIMD_FN_NOT, 5'd8, 5'd1, 5'd0, 2'(w), 3'(p));
				store_reg(5'd8);
			end
		end
		load_reg(5'd0, 16'h10);
		issue_alu(`SIMD_FN_ADD, 5'd0, 5'd1, 5'd2, `SIMD_WW_D, `SIMD_PPP_ALL);
		store_reg(5'd0);
		place_slot({6'b000111, 5'd1, 5'd2, 16'hffff}, 1'b0, 1'b0, '0, '0); // unknown opcode
		place_slot({`SIMD_OP_NOP, 5'd1, 5'd2, 16'h1234}, 1'b0, 1'b0, '0, '0);
		store_reg(5'd1);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		int i;
		int guard;
		RST         = 1'b1;
		seed        = 32'h7497_b98a;
		n_slots     = 0;
		n_stores    = 0;
		stores_seen = 0;
		st_ptr      = 16'h80;
		err_count   = 0;
		timed_out   = 1'b0;
		for (i = 0; i < PROG_SZ; i++) begin
			prog[i]      = {`SIMD_OP_NOP, 26'h0};
			slot_en[i]   = 1'b0;
			slot_wr[i]   = 1'b0;
			slot_addr[i] = '0;
			slot_data[i] = '0;
		end
		for (i = 0; i < MEM_SZ; i++) dmem[i] = {$random(seed), $random(seed)};
		dmem[8'h20] = 64'h80ff_7f01_8001_ffff; // negative lanes at every width
		for (i = 0; i < 32; i++) mreg[i] = '0;
		build_program();

		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b0;

		guard = 0;
		while ((cyc < n_slots + 8) && (guard < LIMIT)) begin
			@(negedge CLK);
			guard++;
		end
		if (guard >= LIMIT) begin
			timed_out = 1'b1;
			$display("timeout: program did not drain within %0d cycles", LIMIT);
		end else begin
			store_count_chk: assert (stores_seen == n_stores)
				else begin
					err_count++;
					$display("[FAIL] %0t: saw %0d stores, expected %0d", $time,
						stores_seen, n_stores);
				end
		end

		$display("errors: pc %0d, strobe %0d, addr %0d, store %0d, count %0d, timeout %0d",
			err_pc, err_strobe, err_addr, err_store, err_count, int'(timed_out));
		if ((err_pc + err_strobe + err_addr + err_store + err_count == 0) && !timed_out) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== simd_cpu_top.sv ====
`timescale 1ns/1ps
`include "simd_cpu_params.svh"

module simd_cpu_top (
	input  logic                     CLK,
	input  logic                     RST,
	input  logic [`SIMD_INSTR_W-1:0] i_instruction,
	input  logic [`SIMD_DATA_W-1:0]  i_data_in,
	output logic [`SIMD_ADDR_W-1:0]  o_pc,
	output logic [`SIMD_DATA_W-1:0]  o_data_out,
	output logic [`SIMD_ADDR_W-1:0]  o_mem_addr,
	output logic                     o_mem_en,
	output logic                     o_mem_wr_en
);

	pipe_ctrl_if dec_ctrl ();
	pipe_ctrl_if ex_ctrl ();
	rf_write_if  rf_wr ();

	logic [`SIMD_DATA_W-1:0] ra_data;
	logic [`SIMD_DATA_W-1:0] rb_data;
	logic [`SIMD_DATA_W-1:0] alu_result;

	// ------------------------------
	// fetch/decode and register read
	// ------------------------------
	fetch_decode u_fetch_decode (
		.CLK           (CLK),
		.RST           (RST),
		.i_instruction (i_instruction),
		.o_pc          (o_pc),
		.o_ctrl        (dec_ctrl)
	);

	reg_file u_reg_file (
		.CLK       (CLK),
		.RST       (RST),
		.i_ra_addr (dec_ctrl.ra),
		.i_rb_addr (dec_ctrl.shamt), // rb field
		.i_wr      (rf_wr),
		.o_ra_data (ra_data),
		.o_rb_data (rb_data)
	);

	// ------------------------------
	// execute/memory and write-back
	// ------------------------------
	execute_stage u_execute_stage (
		.CLK          (CLK),
		.RST          (RST),
		.i_ctrl       (dec_ctrl),
		.i_ra_data    (ra_data),
		.i_rb_data    (rb_data),
		.o_ctrl       (ex_ctrl),
		.o_alu_result (alu_result),
		.o_data_out   (o_data_out),
		.o_mem_addr   (o_mem_addr),
		.o_mem_en     (o_mem_en),
		.o_mem_wr_en  (o_mem_wr_en)
	);

	writeback_stage u_writeback_stage (
		.CLK          (CLK),
		.RST          (RST),
		.i_ctrl       (ex_ctrl),
		.i_alu_result (alu_result),
		.i_mem_data   (i_data_in),
		.o_wr         (rf_wr)
	);

endmodule

// ==== writeback_stage.sv ====
`timescale 1ns/1ps
`include "simd_cpu_params.svh"

module writeback_stage (
	input  logic                    CLK,
	input  logic                    RST,
	pipe_ctrl_if.dst                i_ctrl,
	input  logic [`SIMD_DATA_W-1:0] i_alu_result,
	input  logic [`SIMD_DATA_W-1:0] i_mem_data,
	rf_write_if.src                 o_wr
);

	logic [`SIMD_DATA_W-1:0]     alu_q;
	logic [`SIMD_DATA_W-1:0]     mem_q;
	logic [5:0]                  opcode_q;
	logic [`SIMD_REG_ADDR_W-1:0] rd_q;
	logic [1:0]                  ww_q;
	logic [2:0]                  ppp_q;
	logic                        reg_wr_q;

	// ------------------------------
	// stage register
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			alu_q    <= '0;
			mem_q    <= '0;
			opcode_q <= '0;
			rd_q     <= '0;
			ww_q     <= '0;
			ppp_q    <= '0;
			reg_wr_q <= 1'b0;
		end else begin
			alu_q    <= i_alu_result;
			mem_q    <= i_mem_data;   // load data sampled here
			opcode_q <= i_ctrl.opcode;
			rd_q     <= i_ctrl.rd;
			ww_q     <= i_ctrl.ww;
			ppp_q    <= i_ctrl.ppp;
			reg_wr_q <= i_ctrl.reg_wr;
		end
	end

	// register file port, written on the next edge
	assign o_wr.wr_en = reg_wr_q;
	assign o_wr.addr  = rd_q;
	assign o_wr.ww    = ww_q;
	assign o_wr.ppp   = ppp_q;
	assign o_wr.data  = (opcode_q == `SIMD_OP_LOAD) ? mem_q : alu_q;

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`include "simd_cpu_params.svh"

module execute_stage (
	input  logic                    CLK,
	input  logic                    RST,
	pipe_ctrl_if.dst                i_ctrl,
	input  logic [`SIMD_DATA_W-1:0] i_ra_data,
	input  logic [`SIMD_DATA_W-1:0] i_rb_data,
	pipe_ctrl_if.src                o_ctrl,
	output logic [`SIMD_DATA_W-1:0] o_alu_result,
	output logic [`SIMD_DATA_W-1:0] o_data_out,
	output logic [`SIMD_ADDR_W-1:0] o_mem_addr,
	output logic                    o_mem_en,
	output logic                    o_mem_wr_en
);

	logic [`SIMD_DATA_W-1:0]     a_q;
	logic [`SIMD_DATA_W-1:0]     b_q;
	logic [5:0]                  opcode_q;
	logic [`SIMD_REG_ADDR_W-1:0] rd_q;
	logic [`SIMD_REG_ADDR_W-1:0] ra_q;
	logic [1:0]                  ww_q;
	logic [2:0]                  ppp_q;
	logic [5:0]                  func_q;
	logic [`SIMD_REG_ADDR_W-1:0] shamt_q;
	logic [`SIMD_IADDR_W-1:0]    iaddr_q;
	logic                        reg_wr_q;

	// ------------------------------
	// stage register
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			a_q      <= '0;
			b_q      <= '0;
			opcode_q <= '0;
			rd_q     <= '0;
			ra_q     <= '0;
			ww_q     <= '0;
			ppp_q    <= '0;
			func_q   <= '0;
			shamt_q  <= '0;
			iaddr_q  <= '0;
			reg_wr_q <= 1'b0;
		end else begin
			a_q      <= i_ra_data;
			b_q      <= i_rb_data;
			opcode_q <= i_ctrl.opcode;
			rd_q     <= i_ctrl.rd;
			ra_q     <= i_ctrl.ra;
			ww_q     <= i_ctrl.ww;
			ppp_q    <= i_ctrl.ppp;
			func_q   <= i_ctrl.func;
			shamt_q  <= i_ctrl.shamt;
			iaddr_q  <= i_ctrl.iaddr;
			reg_wr_q <= i_ctrl.reg_wr;
		end
	end

	// controls on to write-back
	assign o_ctrl.opcode = opcode_q;
	assign o_ctrl.rd     = rd_q;
	assign o_ctrl.ra     = ra_q;
	assign o_ctrl.ww     = ww_q;
	assign o_ctrl.ppp    = ppp_q;
	assign o_ctrl.func   = func_q;
	assign o_ctrl.shamt  = shamt_q;
	assign o_ctrl.iaddr  = iaddr_q;
	assign o_ctrl.reg_wr = reg_wr_q;

	simd_alu u_alu (
		.i_func   (func_q),
		.i_ww     (ww_q),
		.i_shamt  (shamt_q),
		.i_a      (a_q),
		.i_b      (b_q),
		.o_result (o_alu_result)
	);

	// ------------------------------
	// data memory side
	// ------------------------------
	assign o_data_out = a_q; // store data is always ra

	always_comb begin
		o_mem_en    = 1'b0;
		o_mem_wr_en = 1'b0;
		o_mem_addr  = '0;
		if ((opcode_q == `SIMD_OP_LOAD) || (opcode_q == `SIMD_OP_STORE)) begin
			o_mem_en    = 1'b1;
			o_mem_wr_en = (opcode_q == `SIMD_OP_STORE);
			o_mem_addr  = {{(`SIMD_ADDR_W - `SIMD_IADDR_W){1'b0}}, iaddr_q};
		end
	end

endmodule

// ==== simd_alu.sv ====
`timescale 1ns/1ps
`include "simd_cpu_params.svh"

module simd_alu (
	input  logic [5:0]                  i_func,
	input  logic [1:0]                  i_ww,
	input  logic [`SIMD_REG_ADDR_W-1:0] i_shamt,
	input  logic [`SIMD_DATA_W-1:0]     i_a,
	input  logic [`SIMD_DATA_W-1:0]     i_b,
	output logic [`SIMD_DATA_W-1:0]     o_result
);

	// one result word per lane width, indexed by ww
	logic [3:0][`SIMD_DATA_W-1:0] sum_v;
	logic [3:0][`SIMD_DATA_W-1:0] diff_v;
	logic [3:0][`SIMD_DATA_W-1:0] sll_v;
	logic [3:0][`SIMD_DATA_W-1:0] srl_v;
	logic [3:0][`SIMD_DATA_W-1:0] sra_v;

	// ------------------------------
	// lane slicing per width
	// ------------------------------
	for (genvar g = 0; g < 4; g++) begin : g_width
		localparam int W  = 8 << g;
		localparam int SB = (g < 2) ? 3 + g : 5; // shamt bits used: 3, 4, 5, 5

		logic [`SIMD_REG_ADDR_W-1:0] sh;

		assign sh = `SIMD_REG_ADDR_W'(i_shamt[SB-1:0]);

		for (genvar l = 0; l < `SIMD_DATA_W / W; l++) begin : g_lane
			logic [W-1:0] a;
			logic [W-1:0] b;

			assign a = i_a[l*W +: W];
			assign b = i_b[l*W +: W];

			assign sum_v[g][l*W +: W]  = a + b;           // wraps in lane
			assign diff_v[g][l*W +: W] = a - b;
			assign sll_v[g][l*W +: W]  = a << sh;
			assign srl_v[g][l*W +: W]  = a >> sh;
			assign sra_v[g][l*W +: W]  = $signed(a) >>> sh; // lane sign fill
		end
	end

	// ------------------------------
	// function select
	// ------------------------------
	always_comb begin
		case (i_func)
			`SIMD_FN_AND:  o_result = i_a & i_b;
			`SIMD_FN_OR:   o_result = i_a | i_b;
			`SIMD_FN_XOR:  o_result = i_a ^ i_b;
			`SIMD_FN_NOT:  o_result = ~i_a;
			`SIMD_FN_MOV:  o_result = i_a;
			`SIMD_FN_ADD:  o_result = sum_v[i_ww];
			`SIMD_FN_SUB:  o_result = diff_v[i_ww];
			`SIMD_FN_SLLI: o_result = sll_v[i_ww];
			`SIMD_FN_SRLI: o_result = srl_v[i_ww];
			`SIMD_FN_SRAI: o_result = sra_v[i_ww];
			default:       o_result = '0;
		endcase
	end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps
`include "simd_cpu_params.svh"

module reg_file (
	input  logic                        CLK,
	input  logic                        RST,
	input  logic [`SIMD_REG_ADDR_W-1:0] i_ra_addr,
	input  logic [`SIMD_REG_ADDR_W-1:0] i_rb_addr,
	rf_write_if.dst                     i_wr,
	output logic [`SIMD_DATA_W-1:0]     o_ra_data,
	output logic [`SIMD_DATA_W-1:0]     o_rb_data
);

	logic [`SIMD_DATA_W-1:0] regs [`SIMD_NUM_REGS];
	logic [`SIMD_DATA_W-1:0] even_mask;
	logic [`SIMD_DATA_W-1:0] wr_mask;

	// async reads
	assign o_ra_data = regs[i_ra_addr];
	assign o_rb_data = regs[i_rb_addr];

	// ------------------------------
	// participation mask
	// ------------------------------

	// lane 0 sits at the msb end
	always_comb begin
		case (i_wr.ww)
			`SIMD_WW_B: even_mask = 64'hff00_ff00_ff00_ff00;
			`SIMD_WW_H: even_mask = 64'hffff_0000_ffff_0000;
			`SIMD_WW_W: even_mask = 64'hffff_ffff_0000_0000;
			default:    even_mask = '1; // single 64-bit lane is lane 0
		endcase
	end

	always_comb begin
		case (i_wr.ppp)
			`SIMD_PPP_ALL:   wr_mask = '1;
			`SIMD_PPP_UPPER: wr_mask = 64'hffff_ffff_0000_0000;
			`SIMD_PPP_LOWER: wr_mask = 64'h0000_0000_ffff_ffff;
			`SIMD_PPP_EVEN:  wr_mask = even_mask;
			`SIMD_PPP_ODD:   wr_mask = ~even_mask; // empty at 64-bit width
			default:         wr_mask = '1;
		endcase
	end

	// ------------------------------
	// write port
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			for (int i = 0; i < `SIMD_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr.wr_en && (i_wr.addr != '0)) begin // r0 stays zero
			regs[i_wr.addr] <= (regs[i_wr.addr] & ~wr_mask) | (i_wr.data & wr_mask);
		end
	end

endmodule

// ==== fetch_decode.sv ====
`timescale 1ns/1ps
`include "simd_cpu_params.svh"

module fetch_decode (
	input  logic                     CLK,
	input  logic                     RST,
	input  logic [`SIMD_INSTR_W-1:0] i_instruction,
	output logic [`SIMD_ADDR_W-1:0]  o_pc,
	pipe_ctrl_if.src                 o_ctrl
);
	import simd_cpu_pkg::*;

	instr_word_t ir;

	// ------------------------------
	// pc and instruction register
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			o_pc <= '0;
			ir   <= '0; // opcode 0 decodes as nop
		end else begin
			o_pc <= o_pc + `SIMD_ADDR_W'(4);
			ir   <= i_instruction;
		end
	end

	// ------------------------------
	// decode
	// ------------------------------
	always_comb begin
		o_ctrl.opcode = `SIMD_OP_NOP;
		o_ctrl.rd     = '0;
		o_ctrl.ra     = '0;
		o_ctrl.ww     = '0;
		o_ctrl.ppp    = '0;
		o_ctrl.func   = '0;
		o_ctrl.shamt  = '0;
		o_ctrl.iaddr  = '0;
		o_ctrl.reg_wr = 1'b0;

		case (ir.r.opcode)
			`SIMD_OP_RTYPE: begin
				o_ctrl.opcode = ir.r.opcode;
				o_ctrl.rd     = ir.r.rd;
				o_ctrl.ra     = ir.r.ra;
				o_ctrl.shamt  = ir.r.rb;
				o_ctrl.ppp    = ir.r.ppp;
				o_ctrl.ww     = ir.r.ww;
				o_ctrl.func   = ir.r.func;
				o_ctrl.reg_wr = 1'b1;
			end
			`SIMD_OP_LOAD: begin
				o_ctrl.opcode = ir.m.opcode;
				o_ctrl.rd     = ir.m.reg_addr;
				o_ctrl.iaddr  = ir.m.iaddr;
				o_ctrl.reg_wr = 1'b1;
			end
			`SIMD_OP_STORE: begin
				o_ctrl.opcode = ir.m.opcode;
				o_ctrl.ra     = ir.m.reg_addr; // store data read through port a
				o_ctrl.iaddr  = ir.m.iaddr;
			end
			default: begin
				// nop and unknown opcodes keep the defaults
			end
		endcase
	end

endmodule

// ==== simd_cpu_ifs.sv ====
`timescale 1ns/1ps
`include "simd_cpu_params.svh"

// decoded controls travelling down the pipe
interface pipe_ctrl_if;
	logic [5:0]                  opcode;
	logic [`SIMD_REG_ADDR_W-1:0] rd;
	logic [`SIMD_REG_ADDR_W-1:0] ra;
	logic [1:0]                  ww;
	logic [2:0]                  ppp;
	logic [5:0]                  func;
	logic [`SIMD_REG_ADDR_W-1:0] shamt;   // rb field
	logic [`SIMD_IADDR_W-1:0]    iaddr;
	logic                        reg_wr;  // r-type and load

	modport src (
		output opcode, rd, ra, ww, ppp, func, shamt, iaddr, reg_wr
	);

	modport dst (
		input opcode, rd, ra, ww, ppp, func, shamt, iaddr, reg_wr
	);
endinterface

// register file write port
interface rf_write_if;
	logic                        wr_en;
	logic [`SIMD_REG_ADDR_W-1:0] addr;
	logic [1:0]                  ww;
	logic [2:0]                  ppp;
	logic [`SIMD_DATA_W-1:0]     data;

	modport src (
		output wr_en, addr, ww, ppp, data
	);

	modport dst (
		input wr_en, addr, ww, ppp, data
	);
endinterface

// ==== simd_cpu_pkg.sv ====
`include "simd_cpu_params.svh"

package simd_cpu_pkg;

	// ------------------------------
	// instruction formats
	// ------------------------------

	// alu ops, rb also carries the shift immediate
	typedef struct packed {
		logic [5:0]                  opcode;
		logic [`SIMD_REG_ADDR_W-1:0] rd;
		logic [`SIMD_REG_ADDR_W-1:0] ra;
		logic [`SIMD_REG_ADDR_W-1:0] rb;
		logic [2:0]                  ppp;
		logic [1:0]                  ww;
		logic [5:0]                  func;
	} r_fmt_t;

	// load / store
	typedef struct packed {
		logic [5:0]                  opcode;
		logic [`SIMD_REG_ADDR_W-1:0] reg_addr; // dest on load, source on store
		logic [`SIMD_REG_ADDR_W-1:0] unused;
		logic [`SIMD_IADDR_W-1:0]    iaddr;
	} m_fmt_t;

	// same word, two views
	typedef union packed {
		r_fmt_t r;
		m_fmt_t m;
	} instr_word_t;

endpackage

// ==== simd_cpu_params.svh ====
`ifndef SIMD_CPU_PARAMS_SVH
`define SIMD_CPU_PARAMS_SVH

// ------------------------------
// widths
// ------------------------------
`define SIMD_DATA_W      64
`define SIMD_INSTR_W     32
`define SIMD_REG_ADDR_W  5
`define SIMD_NUM_REGS    32
`define SIMD_IADDR_W     16
`define SIMD_ADDR_W      32

// ------------------------------
// opcodes and function codes
// ------------------------------
`define SIMD_OP_RTYPE    6'b101010
`define SIMD_OP_LOAD     6'b100000
`define SIMD_OP_STORE    6'b100001
`define SIMD_OP_NOP      6'b111100

`define SIMD_FN_AND      6'd0
`define SIMD_FN_OR       6'd1
`define SIMD_FN_XOR      6'd2
`define SIMD_FN_NOT      6'd3
`define SIMD_FN_MOV      6'd4
`define SIMD_FN_ADD      6'd5
`define SIMD_FN_SUB      6'd6
`define SIMD_FN_SLLI     6'd11
`define SIMD_FN_SRLI     6'd13
`define SIMD_FN_SRAI     6'd15

// participation field
`define SIMD_PPP_ALL     3'd0
`define SIMD_PPP_UPPER   3'd1
`define SIMD_PPP_LOWER   3'd2
`define SIMD_PPP_EVEN    3'd3
`define SIMD_PPP_ODD     3'd4

// lane width field
`define SIMD_WW_B        2'd0
`define SIMD_WW_H        2'd1
`define SIMD_WW_W        2'd2
`define SIMD_WW_D        2'd3

`endif
